//--- hw/sb_params.svh
`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

// ******************************
// Store buffer geometry
// ******************************

// Number of direct-mapped entries
`define SB_DEPTH 16

// Entry index width, taken from address bits 3 upward
`define SB_INDEX_W 4

`define SB_ADDR_W 32

// One doubleword per entry
`define SB_DATA_W 64

`define SB_STRB_W 8

`endif

//--- hw/sb_line_pkg.sv
`default_nettype none

`include "sb_params.svh"

package sb_line_pkg;

  // ******************************
  // One stored doubleword
  // ******************************

  // The merge works byte by byte, everything else moves the whole word
  typedef union packed {
    logic [`SB_DATA_W-1:0]      dword;
    logic [`SB_STRB_W-1:0][7:0] bytes;
  } line_data_u;

  // ******************************
  // One buffer entry
  // ******************************

  typedef struct packed {
    logic                  valid;
    logic                  dirty; // Differs from memory and needs a writeback
    logic [`SB_ADDR_W-1:0] tag;   // Doubleword-aligned address of the data
    line_data_u            data;
  } sb_entry_t;

endpackage

`default_nettype wire

//--- hw/sb_bus_pkg.sv
`default_nettype none

package sb_bus_pkg;

  // ******************************
  // Miss controller states
  // ******************************

  // A clean victim goes straight from idle to refill.
  // Writeback and refill both wait on mem_ready for as long as memory needs
  typedef enum logic [2:0] {
    miss_idle      = 3'd0,
    miss_writeback = 3'd1, // Dirty victim goes out to its own address
    miss_refill    = 3'd2, // Read of the requested doubleword
    miss_install   = 3'd3  // Fill entry handed to the owning port
  } miss_state_e;

endpackage

`default_nettype wire

//--- hw/sb_entry_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module sb_entry_array (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [`SB_INDEX_W-1:0] raddr0,
  input  logic [`SB_INDEX_W-1:0] raddr1,
  output sb_line_pkg::sb_entry_t rentry0,
  output sb_line_pkg::sb_entry_t rentry1,
  input  logic                   wen0,
  input  logic                   wen1,
  input  logic [`SB_INDEX_W-1:0] waddr0,
  input  logic [`SB_INDEX_W-1:0] waddr1,
  input  sb_line_pkg::sb_entry_t wentry0,
  input  sb_line_pkg::sb_entry_t wentry1
);

  sb_line_pkg::sb_entry_t entries [`SB_DEPTH];
  logic [`SB_DEPTH-1:0]   valid_bits; // Authoritative valid flags
  sb_line_pkg::sb_entry_t stored0;
  sb_line_pkg::sb_entry_t stored1;

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_bits <= '0;
    end else begin
      if (wen0) valid_bits[waddr0] <= wentry0.valid;
      if (wen1) valid_bits[waddr1] <= wentry1.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (wen0) entries[waddr0] <= wentry0;
    if (wen1) entries[waddr1] <= wentry1;
  end

  // Pending writes are seen by a read in the same cycle, port 0 first
  always_comb begin
    stored0 = entries[raddr0];
    stored0.valid = valid_bits[raddr0];
    stored1 = entries[raddr1];
    stored1.valid = valid_bits[raddr1];
    if (wen0 && (waddr0 == raddr0)) rentry0 = wentry0;
    else if (wen1 && (waddr1 == raddr0)) rentry0 = wentry1;
    else rentry0 = stored0;
    if (wen0 && (waddr0 == raddr1)) rentry1 = wentry0;
    else if (wen1 && (waddr1 == raddr1)) rentry1 = wentry1;
    else rentry1 = stored1;
  end

endmodule

`default_nettype wire

//--- hw/sb_port_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module sb_port_lookup (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   valid,
  input  logic [`SB_ADDR_W-1:0]  addr,
  input  logic [`SB_DATA_W-1:0]  wdata,
  input  logic [`SB_STRB_W-1:0]  wstrb,
  output logic                   ready,
  output logic [`SB_DATA_W-1:0]  rdata,
  input  logic                   hold,
  output logic [`SB_INDEX_W-1:0] raddr,
  input  sb_line_pkg::sb_entry_t rentry,
  output logic                   wen,
  output logic [`SB_INDEX_W-1:0] waddr,
  output sb_line_pkg::sb_entry_t wentry,
  output logic                   miss,
  output logic [`SB_ADDR_W-1:0]  miss_addr,
  output sb_line_pkg::sb_entry_t victim,
  input  logic                   fill_valid,
  input  sb_line_pkg::sb_entry_t fill_entry
);

  logic [`SB_ADDR_W-1:0]  line_addr;
  logic                   accept;
  logic                   hit;
  logic                   is_store;
  sb_line_pkg::line_data_u store_word;
  sb_line_pkg::sb_entry_t merged;

  // ******************************
  // Lookup
  // ******************************

  assign line_addr = {addr[`SB_ADDR_W-1:3], 3'b000};
  assign raddr     = addr[3 +: `SB_INDEX_W];
  assign is_store  = |wstrb; // No strobes means a load
  assign accept    = valid && !hold;
  assign hit       = rentry.valid && (rentry.tag == line_addr);

  assign miss      = accept && !hit;
  assign miss_addr = line_addr;
  assign victim    = rentry;

  always_comb begin
    store_word.dword = wdata;
    merged = rentry;
    merged.dirty = 1'b1;
    for (int i = 0; i < `SB_STRB_W; i++) begin
      if (wstrb[i]) begin
        merged.data.bytes[i] = store_word.bytes[i];
      end
    end
  end

  // ******************************
  // Response and write stage
  // ******************************

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready <= 1'b0;
      wen   <= 1'b0;
    end else begin
      ready <= accept && hit;
      wen   <= fill_valid || (accept && hit && is_store);
    end
  end

  always_ff @(posedge clock) begin
    if (accept && hit) begin
      rdata <= is_store ? '0 : rentry.data.dword;
    end
  end

  // The write lands one cycle after the lookup, the array bypass covers the gap
  always_ff @(posedge clock) begin
    if (fill_valid) begin
      waddr  <= fill_entry.tag[3 +: `SB_INDEX_W];
      wentry <= fill_entry;
    end else begin
      waddr  <= raddr;
      wentry <= merged;
    end
  end

endmodule

`default_nettype wire

//--- hw/sb_miss_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module sb_miss_ctrl (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   miss0,
  input  logic                   miss1,
  input  logic [`SB_ADDR_W-1:0]  miss_addr0,
  input  logic [`SB_ADDR_W-1:0]  miss_addr1,
  input  sb_line_pkg::sb_entry_t victim0,
  input  sb_line_pkg::sb_entry_t victim1,
  input  logic                   valid0,
  input  logic                   valid1,
  input  logic [`SB_ADDR_W-1:0]  addr0,
  input  logic [`SB_ADDR_W-1:0]  addr1,
  output logic                   hold0,
  output logic                   hold1,
  output logic                   fill_valid0,
  output logic                   fill_valid1,
  output sb_line_pkg::sb_entry_t fill_entry,
  output logic                   mem_valid,
  output logic                   mem_store,
  output logic [`SB_ADDR_W-1:0]  mem_addr,
  output logic [`SB_DATA_W-1:0]  mem_wdata,
  input  logic                   mem_ready,
  input  logic [`SB_DATA_W-1:0]  mem_rdata
);

  sb_bus_pkg::miss_state_e  state;
  sb_bus_pkg::miss_state_e  state_next;
  logic                     owner;       // Port whose miss is being served
  logic [`SB_ADDR_W-1:0]    req_addr;
  sb_line_pkg::sb_entry_t   victim_q;
  sb_line_pkg::line_data_u  refill_data;
  logic                     yield_q;     // Port 0 gives way on the next index conflict
  logic                     busy;
  logic                     same_index;
  logic [`SB_INDEX_W-1:0]   pend_index;

  // ******************************
  // Miss sequencing
  // ******************************

  always_comb begin
    state_next = state;
    case (state)
      sb_bus_pkg::miss_idle: begin
        if (miss0) begin
          state_next = (victim0.valid && victim0.dirty) ? sb_bus_pkg::miss_writeback
                                                        : sb_bus_pkg::miss_refill;
        end else if (miss1) begin
          state_next = (victim1.valid && victim1.dirty) ? sb_bus_pkg::miss_writeback
                                                        : sb_bus_pkg::miss_refill;
        end
      end
      sb_bus_pkg::miss_writeback: begin
        if (mem_ready) state_next = sb_bus_pkg::miss_refill;
      end
      sb_bus_pkg::miss_refill: begin
        if (mem_ready) state_next = sb_bus_pkg::miss_install;
      end
      default: begin
        state_next = sb_bus_pkg::miss_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state   <= sb_bus_pkg::miss_idle;
      owner   <= 1'b0;
      yield_q <= 1'b0;
    end else begin
      state <= state_next;
      if (busy == 1'b0 && (miss0 || miss1)) owner <= !miss0;
      // The port that just installed wins the first conflict after it
      if (state == sb_bus_pkg::miss_install) yield_q <= owner;
      else yield_q <= same_index && !yield_q;
    end
  end

  always_ff @(posedge clock) begin
    if (!busy && miss0) begin
      req_addr <= miss_addr0;
      victim_q <= victim0;
    end else if (!busy && miss1) begin
      req_addr <= miss_addr1;
      victim_q <= victim1;
    end
    if (state == sb_bus_pkg::miss_refill && mem_ready) refill_data.dword <= mem_rdata;
  end

  // ******************************
  // Holds, fill and memory port
  // ******************************

  assign busy       = (state != sb_bus_pkg::miss_idle);
  assign pend_index = req_addr[3 +: `SB_INDEX_W];
  assign same_index = valid0 && valid1 &&
                      (addr0[3 +: `SB_INDEX_W] == addr1[3 +: `SB_INDEX_W]);

  // Nothing touches the pending index until its fill is installed
  assign hold0 = (busy && (addr0[3 +: `SB_INDEX_W] == pend_index)) || (same_index && yield_q);
  assign hold1 = (busy && (addr1[3 +: `SB_INDEX_W] == pend_index)) || (same_index && !yield_q);

  assign fill_valid0 = (state == sb_bus_pkg::miss_install) && !owner;
  assign fill_valid1 = (state == sb_bus_pkg::miss_install) && owner;

  always_comb begin
    fill_entry.valid = 1'b1;
    fill_entry.dirty = 1'b0; // Installed clean
    fill_entry.tag   = req_addr;
    fill_entry.data  = refill_data;
  end

  assign mem_valid = (state == sb_bus_pkg::miss_writeback) || (state == sb_bus_pkg::miss_refill);
  assign mem_store = (state == sb_bus_pkg::miss_writeback);
  assign mem_addr  = (state == sb_bus_pkg::miss_writeback) ? victim_q.tag : req_addr;
  assign mem_wdata = victim_q.data.dword;

endmodule

`default_nettype wire

//--- hw/store_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module store_buffer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  p0_valid,
  input  logic [`SB_ADDR_W-1:0] p0_addr,
  input  logic [`SB_DATA_W-1:0] p0_wdata,
  input  logic [`SB_STRB_W-1:0] p0_wstrb,
  output logic                  p0_ready,
  output logic [`SB_DATA_W-1:0] p0_rdata,
  input  logic                  p1_valid,
  input  logic [`SB_ADDR_W-1:0] p1_addr,
  input  logic [`SB_DATA_W-1:0] p1_wdata,
  input  logic [`SB_STRB_W-1:0] p1_wstrb,
  output logic                  p1_ready,
  output logic [`SB_DATA_W-1:0] p1_rdata,
  output logic                  mem_valid,
  output logic                  mem_store,
  output logic [`SB_ADDR_W-1:0] mem_addr,
  output logic [`SB_DATA_W-1:0] mem_wdata,
  input  logic                  mem_ready,
  input  logic [`SB_DATA_W-1:0] mem_rdata
);

  logic [`SB_INDEX_W-1:0] raddr0, raddr1, waddr0, waddr1;
  sb_line_pkg::sb_entry_t rentry0, rentry1, wentry0, wentry1;
  sb_line_pkg::sb_entry_t victim0, victim1, fill_entry;
  logic                   wen0, wen1, miss0, miss1;
  logic                   hold0, hold1, fill_valid0, fill_valid1;
  logic [`SB_ADDR_W-1:0]  miss_addr0, miss_addr1;

  sb_entry_array entry_array_comp (
    .clock, .reset, .raddr0, .raddr1, .rentry0, .rentry1,
    .wen0, .wen1, .waddr0, .waddr1, .wentry0, .wentry1
  );

  // ******************************
  // Load/store ports
  // ******************************

  sb_port_lookup port0_lookup_comp (
    .clock, .reset, .valid(p0_valid), .addr(p0_addr), .wdata(p0_wdata),
    .wstrb(p0_wstrb), .ready(p0_ready), .rdata(p0_rdata), .hold(hold0),
    .raddr(raddr0), .rentry(rentry0), .wen(wen0), .waddr(waddr0), .wentry(wentry0),
    .miss(miss0), .miss_addr(miss_addr0), .victim(victim0),
    .fill_valid(fill_valid0), .fill_entry(fill_entry)
  );

  sb_port_lookup port1_lookup_comp (
    .clock, .reset, .valid(p1_valid), .addr(p1_addr), .wdata(p1_wdata),
    .wstrb(p1_wstrb), .ready(p1_ready), .rdata(p1_rdata), .hold(hold1),
    .raddr(raddr1), .rentry(rentry1), .wen(wen1), .waddr(waddr1), .wentry(wentry1),
    .miss(miss1), .miss_addr(miss_addr1), .victim(victim1),
    .fill_valid(fill_valid1), .fill_entry(fill_entry)
  );

  sb_miss_ctrl miss_ctrl_comp (
    .clock, .reset, .miss0, .miss1, .miss_addr0, .miss_addr1, .victim0, .victim1,
    .valid0(p0_valid), .valid1(p1_valid), .addr0(p0_addr), .addr1(p1_addr),
    .hold0, .hold1, .fill_valid0, .fill_valid1, .fill_entry,
    .mem_valid, .mem_store, .mem_addr, .mem_wdata, .mem_ready, .mem_rdata
  );

endmodule

`default_nettype wire

//--- tb/store_buffer_asserts.sv
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module store_buffer_asserts (
  input logic                    clock,
  input logic                    reset,
  input logic                    p0_valid,
  input logic [`SB_STRB_W-1:0]   p0_wstrb,
  input logic                    p0_ready,
  input logic [`SB_DATA_W-1:0]   p0_rdata,
  input logic                    p1_valid,
  input logic [`SB_STRB_W-1:0]   p1_wstrb,
  input logic                    p1_ready,
  input logic [`SB_DATA_W-1:0]   p1_rdata,
  input logic                    mem_valid,
  input logic                    mem_store,
  input logic [`SB_ADDR_W-1:0]   mem_addr,
  input logic [`SB_DATA_W-1:0]   mem_wdata,
  input logic                    mem_ready,
  input sb_bus_pkg::miss_state_e miss_state
);

  int failures = 0;

  // ******************************
  // Port handshake
  // ******************************

  p0_ready_needs_valid: assert property (@(posedge clock) disable iff (!reset)
    p0_ready |-> $past(p0_valid))
  else begin
    $error("Port 0 raised ready without a request");
    failures++;
  end

  p1_ready_needs_valid: assert property (@(posedge clock) disable iff (!reset)
    p1_ready |-> $past(p1_valid))
  else begin
    $error("Port 1 raised ready without a request");
    failures++;
  end

  // Inputs have already moved on when ready is sampled, so the store is judged a cycle back
  p0_store_rdata_zero: assert property (@(posedge clock) disable iff (!reset)
    p0_ready && ($past(p0_wstrb) != '0) |-> p0_rdata == '0)
  else begin
    $error("Port 0 returned nonzero data for a store");
    failures++;
  end

  p1_store_rdata_zero: assert property (@(posedge clock) disable iff (!reset)
    p1_ready && ($past(p1_wstrb) != '0) |-> p1_rdata == '0)
  else begin
    $error("Port 1 returned nonzero data for a store");
    failures++;
  end

  // ******************************
  // Memory port and reset
  // ******************************

  mem_request_stable: assert property (@(posedge clock) disable iff (!reset)
    mem_valid && !mem_ready |=>
      mem_valid && $stable(mem_store) && $stable(mem_addr) && $stable(mem_wdata))
  else begin
    $error("Memory request changed before mem_ready");
    failures++;
  end

  reset_quiet: assert property (@(posedge clock)
    !reset |=> !p0_ready && !p1_ready && !mem_valid && miss_state == sb_bus_pkg::miss_idle)
  else begin
    $error("Ready, mem_valid or miss state not cleared by reset");
    failures++;
  end

endmodule

bind store_buffer store_buffer_asserts store_buffer_checks (
  .clock, .reset,
  .p0_valid, .p0_wstrb, .p0_ready, .p0_rdata,
  .p1_valid, .p1_wstrb, .p1_ready, .p1_rdata,
  .mem_valid, .mem_store, .mem_addr, .mem_wdata, .mem_ready,
  .miss_state(miss_ctrl_comp.state)
);

`default_nettype wire

//--- tb/store_buffer_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module store_buffer_tb;

  localparam int TOTAL_OPS      = 300;
  localparam int DIRECTED_OPS   = 16;
  localparam int CYCLES_PER_OP  = 40;
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * CYCLES_PER_OP + 20;
  localparam int RANDOM_PER_PORT = (TOTAL_OPS - DIRECTED_OPS) / 2;

  logic                  clock;
  logic                  reset;
  logic                  p0_valid;
  logic [`SB_ADDR_W-1:0] p0_addr;
  logic [`SB_DATA_W-1:0] p0_wdata;
  logic [`SB_STRB_W-1:0] p0_wstrb;
  logic                  p0_ready;
  logic [`SB_DATA_W-1:0] p0_rdata;
  logic                  p1_valid;
  logic [`SB_ADDR_W-1:0] p1_addr;
  logic [`SB_DATA_W-1:0] p1_wdata;
  logic [`SB_STRB_W-1:0] p1_wstrb;
  logic                  p1_ready;
  logic [`SB_DATA_W-1:0] p1_rdata;
  logic                  mem_valid;
  logic                  mem_store;
  logic [`SB_ADDR_W-1:0] mem_addr;
  logic [`SB_DATA_W-1:0] mem_wdata;
  logic                  mem_ready;
  logic [`SB_DATA_W-1:0] mem_rdata;

  logic [`SB_DATA_W-1:0] backing [logic [`SB_ADDR_W-1:0]]; // Memory behind the buffer
  logic [7:0]            image [logic [`SB_ADDR_W-1:0]];   // Bytes as the core sees them
  int                    error_count = 0;
  int                    cycle_count = 0;
  int                    wb_count = 0;
  logic [`SB_ADDR_W-1:0] last_wb_addr;
  logic [`SB_DATA_W-1:0] last_wb_data;
  string                 current_test = "reset_load";

  store_buffer DUT (.*);

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a request never completed", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ******************************
  // Reference image
  // ******************************

  // Untouched memory content depends on every address bit
  function automatic logic [63:0] init_pattern(input logic [31:0] addr);
    return {addr ^ 32'h9e37_79b9, {addr[15:0], addr[31:16]} + 32'h7f4a_7c15};
  endfunction

  function automatic logic [63:0] ref_read(input logic [31:0] addr);
    logic [31:0] base;
    logic [63:0] word;
    base = {addr[31:3], 3'b000};
    word = init_pattern(base);
    for (int i = 0; i < 8; i++) begin
      if (image.exists(base + i)) word[8*i +: 8] = image[base + i];
    end
    return word;
  endfunction

  function automatic void ref_write(input logic [31:0] addr, input logic [63:0] wdata,
                                    input logic [7:0] wstrb);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    for (int i = 0; i < 8; i++) begin
      if (wstrb[i]) image[base + i] = wdata[8*i +: 8];
    end
  endfunction

  // ******************************
  // Memory model
  // ******************************

  task automatic serve_memory();
    int unsigned delay;
    forever begin
      @(negedge clock);
      if (mem_valid) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clock);
        if (mem_store) begin
          // A dirty entry going out must hold exactly what the core wrote
          assert (mem_wdata == ref_read(mem_addr)) else begin
            error_count++;
            $display("FAIL %s writeback: addr %h expected %h actual %h",
                     current_test, mem_addr, ref_read(mem_addr), mem_wdata);
          end
          backing[mem_addr] = mem_wdata;
          wb_count++;
          last_wb_addr = mem_addr;
          last_wb_data = mem_wdata;
        end else begin
          mem_rdata = backing.exists(mem_addr) ? backing[mem_addr] : init_pattern(mem_addr);
        end
        mem_ready = 1'b1;
        @(negedge clock);
        mem_ready = 1'b0;
      end
    end
  endtask

  // ******************************
  // Port driver and checks
  // ******************************

  task automatic drive_port(input int port, input logic valid, input logic [31:0] addr,
                            input logic [63:0] wdata, input logic [7:0] wstrb);
    if (port == 0) begin
      p0_valid = valid;
      p0_addr  = addr;
      p0_wdata = wdata;
      p0_wstrb = wstrb;
    end else begin
      p1_valid = valid;
      p1_addr  = addr;
      p1_wdata = wdata;
      p1_wstrb = wstrb;
    end
  endtask

  // Starts on a falling edge and returns on the falling edge that saw ready
  task automatic access(input int port, input logic [31:0] addr, input logic [63:0] wdata,
                        input logic [7:0] wstrb, input string name);
    logic        seen;
    logic [63:0] actual;
    logic [63:0] expected;
    current_test = name;
    drive_port(port, 1'b1, addr, wdata, wstrb);
    seen = 1'b0;
    while (!seen) begin
      @(negedge clock);
      seen = (port == 0) ? p0_ready : p1_ready;
    end
    actual = (port == 0) ? p0_rdata : p1_rdata;
    drive_port(port, 1'b0, '0, '0, '0);
    if (wstrb == '0) begin
      expected = ref_read(addr);
      assert (actual == expected) else begin
        error_count++;
        $display("FAIL %s: port %0d load %h expected %h actual %h",
                 name, port, addr, expected, actual);
      end
    end else begin
      ref_write(addr, wdata, wstrb);
    end
  endtask

  task automatic random_traffic(input int port, input int count);
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    for (int n = 0; n < count; n++) begin
      // Four tags over all sixteen indices keeps evictions frequent
      addr  = 32'h0001_0000 | ($urandom_range(3, 0) << 7) | ($urandom_range(15, 0) << 3);
      wdata = {$urandom, $urandom};
      wstrb = ($urandom_range(1, 0) == 0) ? 8'h00 : 8'($urandom);
      if ($urandom_range(3, 0) == 0) @(negedge clock);
      access(port, addr, wdata, wstrb, "random_traffic");
    end
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    int wb_before;
    void'($urandom(32'hacac6ed1));
    clock     = 1'b0;
    reset     = 1'b0;
    mem_ready = 1'b0;
    mem_rdata = '0;
    drive_port(0, 1'b0, '0, '0, '0);
    drive_port(1, 1'b0, '0, '0, '0);
    fork
      serve_memory();
    join_none
    repeat (5) @(negedge clock);
    reset = 1'b1;

    repeat (3) begin
      @(negedge clock);
      assert (!p0_ready && !p1_ready && !mem_valid) else begin
        error_count++;
        $display("Reset: ready or mem_valid raised with no request pending");
      end
    end
    access(0, 32'h0000_1000, '0, 8'h00, "reset_load");

    access(0, 32'h0000_1000, 64'h1122_3344_5566_7788, 8'h0f, "store_merge");
    access(0, 32'h0000_1000, '0, 8'h00, "store_merge");
    access(0, 32'h0000_1000, 64'hdead_beef_cafe_f00d, 8'ha0, "store_merge");
    access(0, 32'h0000_1000, '0, 8'h00, "store_merge");
    access(1, 32'h0000_2008, 64'h0123_4567_89ab_cdef, 8'hc3, "store_merge");
    access(1, 32'h0000_2008, '0, 8'h00, "store_merge");

    // 0x3010 and 0x4010 share index 2
    access(0, 32'h0000_3010, 64'ha5a5_5a5a_0f0f_f0f0, 8'hff, "same_index_evict");
    wb_before = wb_count;
    access(0, 32'h0000_4010, 64'h7777_6666_5555_4444, 8'h0f, "same_index_evict");
    assert (wb_count == wb_before + 1) else begin
      error_count++;
      $display("same_index_evict: the dirty entry was not written back to memory");
    end
    assert (last_wb_addr == 32'h0000_3010) else begin
      error_count++;
      $display("FAIL same_index_evict: writeback addr expected %h actual %h",
               32'h0000_3010, last_wb_addr);
    end
    assert (last_wb_data == 64'ha5a5_5a5a_0f0f_f0f0) else begin
      error_count++;
      $display("FAIL same_index_evict: writeback data expected %h actual %h",
               64'ha5a5_5a5a_0f0f_f0f0, last_wb_data);
    end
    access(0, 32'h0000_3010, '0, 8'h00, "same_index_evict");
    access(0, 32'h0000_4010, '0, 8'h00, "same_index_evict");

    fork
      access(0, 32'h0000_5028, 64'h1357_9bdf_2468_ace0, 8'hff, "dual_port_split");
      access(1, 32'h0000_6048, '0, 8'h00, "dual_port_split");
    join
    fork
      access(0, 32'h0000_7038, 64'hfeed_face_0bad_c0de, 8'h3c, "dual_port_shared");
      access(1, 32'h0000_7038, '0, 8'h00, "dual_port_shared");
    join
    access(1, 32'h0000_7038, '0, 8'h00, "dual_port_shared");

    fork
      random_traffic(0, RANDOM_PER_PORT);
      random_traffic(1, RANDOM_PER_PORT);
    join

    repeat (2) @(negedge clock);
    $display("Errors: %0d check failures, %0d assertion failures",
             error_count, DUT.store_buffer_checks.failures);
    if (error_count == 0 && DUT.store_buffer_checks.failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hw
hw/sb_line_pkg.sv
hw/sb_bus_pkg.sv
hw/sb_entry_array.sv
hw/sb_port_lookup.sv
hw/sb_miss_ctrl.sv
hw/store_buffer.sv
tb/store_buffer_asserts.sv
tb/store_buffer_tb.sv
